/* hdl/ipu_core.sv */
//////////////////////////////////////////////////
// Integer processing core with operand distributor,
// four SIMD lanes, result collector and byte enables
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipu_core (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Operation
  input  ipu_pkg::op_e                operation_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_s1_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_s2_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_d_i,
  input  logic [ipu_pkg::ELENB-1:0]   carry_i,
  input  ipu_pkg::vew_e               sew_i,
  input  logic [ipu_pkg::ACT_W-1:0]   act_elems_i,
  // Result
  output logic [ipu_pkg::ELENB-1:0]   be_o,
  output logic [ipu_pkg::ELEN-1:0]    result_o
);

  import ipu_pkg::*;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  logic is_signed;

  // Lane operands
  logic [1:0][7:0] ew8_s1, ew8_s2, ew8_d;
  logic [15:0]     ew16_s1, ew16_s2, ew16_d;
  logic [31:0]     ew32_s1, ew32_s2, ew32_d;

  // Lane carries
  logic [1:0]      ew8_carry;
  logic            ew16_carry;
  logic            ew32_carry;

  // Lane results
  logic [1:0][7:0] ew8_res;
  logic [15:0]     ew16_res;
  logic [31:0]     ew32_res;

  assign is_signed = operation_i inside {VMIN, VMAX, VMULH};

  //////////////////////////////////////////////////
  // Distributor
  //////////////////////////////////////////////////

  // Narrow elements in wide lanes are sign or zero extended
  always_comb begin
    ew8_s1     = '0;
    ew8_s2     = '0;
    ew8_d      = '0;
    ew8_carry  = '0;
    ew16_s1    = '0;
    ew16_s2    = '0;
    ew16_d     = '0;
    ew16_carry = 1'b0;
    ew32_carry = 1'b0;
    case (sew_i)
      EW_8: begin
        ew8_s1     = op_s1_i[15:0];
        ew8_s2     = op_s2_i[15:0];
        ew8_d      = op_d_i[15:0];
        ew16_s1    = {{8{is_signed & op_s1_i[23]}}, op_s1_i[23:16]};
        ew16_s2    = {{8{is_signed & op_s2_i[23]}}, op_s2_i[23:16]};
        ew16_d     = {{8{is_signed & op_d_i[23]}}, op_d_i[23:16]};
        ew32_s1    = {{24{is_signed & op_s1_i[31]}}, op_s1_i[31:24]};
        ew32_s2    = {{24{is_signed & op_s2_i[31]}}, op_s2_i[31:24]};
        ew32_d     = {{24{is_signed & op_d_i[31]}}, op_d_i[31:24]};
        ew8_carry  = carry_i[1:0];
        ew16_carry = carry_i[2];
        ew32_carry = carry_i[3];
      end
      EW_16: begin
        ew16_s1    = op_s1_i[15:0];
        ew16_s2    = op_s2_i[15:0];
        ew16_d     = op_d_i[15:0];
        ew32_s1    = {{16{is_signed & op_s1_i[31]}}, op_s1_i[31:16]};
        ew32_s2    = {{16{is_signed & op_s2_i[31]}}, op_s2_i[31:16]};
        ew32_d     = {{16{is_signed & op_d_i[31]}}, op_d_i[31:16]};
        ew16_carry = carry_i[0];
        ew32_carry = carry_i[1];
      end
      default: begin
        // Whole word in the 32 bit lane
        ew32_s1    = op_s1_i;
        ew32_s2    = op_s2_i;
        ew32_d     = op_d_i;
        ew32_carry = carry_i[0];
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Collector
  //////////////////////////////////////////////////

  always_comb begin
    case (sew_i)
      EW_8:    result_o = {ew32_res[7:0], ew16_res[7:0], ew8_res[1], ew8_res[0]};
      EW_16:   result_o = {ew32_res[15:0], ew16_res};
      default: result_o = ew32_res;
    endcase
  end

  // Byte b is enabled when its element index is below the count
  always_comb begin
    for (int b = 0; b < ELENB; b++) begin
      case (sew_i)
        EW_8:    be_o[b] = ACT_W'(b) < act_elems_i;
        EW_16:   be_o[b] = ACT_W'(b >> 1) < act_elems_i;
        default: be_o[b] = ACT_W'(b >> 2) < act_elems_i;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // SIMD lanes
  //////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : gen_lane_8b
    ipu_simd_lane #(
      .Width (8)
    ) i_simd_lane_8b (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .operation_i (operation_i),
      .op_s1_i     (ew8_s1[i]),
      .op_s2_i     (ew8_s2[i]),
      .op_d_i      (ew8_d[i]),
      .is_signed_i (is_signed),
      .carry_i     (ew8_carry[i]),
      .sew_i       (sew_i),
      .result_o    (ew8_res[i])
    );
  end

  ipu_simd_lane #(
    .Width (16)
  ) i_simd_lane_16b (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operation_i (operation_i),
    .op_s1_i     (ew16_s1),
    .op_s2_i     (ew16_s2),
    .op_d_i      (ew16_d),
    .is_signed_i (is_signed),
    .carry_i     (ew16_carry),
    .sew_i       (sew_i),
    .result_o    (ew16_res)
  );

  ipu_simd_lane #(
    .Width (32)
  ) i_simd_lane_32b (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operation_i (operation_i),
    .op_s1_i     (ew32_s1),
    .op_s2_i     (ew32_s2),
    .op_d_i      (ew32_d),
    .is_signed_i (is_signed),
    .carry_i     (ew32_carry),
    .sew_i       (sew_i),
    .result_o    (ew32_res)
  );

endmodule : ipu_core

`default_nettype wire

/* hdl/ipu_pkg.sv */
//////////////////////////////////////////////////
// Shared constants, operation and element width
// encodings for the integer processing unit
//////////////////////////////////////////////////

`default_nettype none

package ipu_pkg;

  //////////////////////////////////////////////////
  // Word geometry
  //////////////////////////////////////////////////

  // Operation word width in bits
  localparam int unsigned ELEN = 32;
  // Bytes per operation word
  localparam int unsigned ELENB = ELEN / 8;
  // Active element count, covers 0 to 4
  localparam int unsigned ACT_W = 3;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VADC,
    VSBC,
    VAND,
    VOR,
    VXOR,
    VMINU,
    VMIN,
    VMAXU,
    VMAX,
    VMUL,
    VMULH,
    VMACC
  } op_e;

  // Packed element width
  typedef enum logic [1:0] {
    EW_8  = 2'b00,
    EW_16 = 2'b01,
    EW_32 = 2'b10
  } vew_e;

  // Element width in bits
  function automatic logic [5:0] sew_bits(vew_e sew);
    case (sew)
      EW_8:    return 6'd8;
      EW_16:   return 6'd16;
      default: return 6'd32;
    endcase
  endfunction

endpackage : ipu_pkg

`default_nettype wire

/* hdl/ipu_simd_lane.sv */
//////////////////////////////////////////////////
// One SIMD lane of the integer processing unit
// Arithmetic, logic, min/max and multiply ops
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipu_simd_lane #(
  parameter int unsigned Width = 32
) (
  // No state in the lane
  // Clock and reset only keep the port list uniform with the core
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Operation and operands
  input  ipu_pkg::op_e       operation_i,
  input  logic [Width-1:0]   op_s1_i,
  input  logic [Width-1:0]   op_s2_i,
  input  logic [Width-1:0]   op_d_i,
  input  logic               is_signed_i,
  input  logic               carry_i,
  input  ipu_pkg::vew_e      sew_i,
  // Lane result
  output logic [Width-1:0]   result_o
);

  import ipu_pkg::*;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Multiplier operands carry one extra bit for the sign
  logic signed [Width:0]     mul_a;
  logic signed [Width:0]     mul_b;
  logic signed [2*Width+1:0] mul_full;
  logic [2*Width+1:0]        mul_shifted;
  logic [5:0]                mulh_shift;
  logic [Width-1:0]          mul_low;

  logic                      s1_lt_s2;
  logic [Width-1:0]          min_res;
  logic [Width-1:0]          max_res;

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  // Unsigned operands get a zero sign bit
  assign mul_a    = {is_signed_i & op_s1_i[Width-1], op_s1_i};
  assign mul_b    = {is_signed_i & op_s2_i[Width-1], op_s2_i};
  assign mul_full = mul_a * mul_b;
  assign mul_low  = mul_full[Width-1:0];

  // High half starts at the element width.
  // A wider lane may hold a sign-extended narrow element, so the
  // full product is exact and the shift picks bits 2*SEW-1:SEW
  always_comb begin
    if (sew_bits(sew_i) > 6'(Width)) begin
      mulh_shift = 6'(Width);
    end else begin
      mulh_shift = sew_bits(sew_i);
    end
  end

  assign mul_shifted = mul_full >> mulh_shift;

  //////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////

  always_comb begin
    if (is_signed_i) begin
      s1_lt_s2 = $signed(op_s1_i) < $signed(op_s2_i);
    end else begin
      s1_lt_s2 = op_s1_i < op_s2_i;
    end
  end

  assign min_res = s1_lt_s2 ? op_s1_i : op_s2_i;
  assign max_res = s1_lt_s2 ? op_s2_i : op_s1_i;

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    case (operation_i)
      VADD: begin
        result_o = op_s1_i + op_s2_i;
      end
      VSUB: begin
        result_o = op_s1_i - op_s2_i;
      end
      // Carry and borrow enter at bit 0
      VADC: begin
        result_o = op_s1_i + op_s2_i + Width'(carry_i);
      end
      VSBC: begin
        result_o = op_s1_i - op_s2_i - Width'(carry_i);
      end
      VAND: begin
        result_o = op_s1_i & op_s2_i;
      end
      VOR: begin
        result_o = op_s1_i | op_s2_i;
      end
      VXOR: begin
        result_o = op_s1_i ^ op_s2_i;
      end
      VMINU, VMIN: begin
        result_o = min_res;
      end
      VMAXU, VMAX: begin
        result_o = max_res;
      end
      VMUL: begin
        result_o = mul_low;
      end
      VMULH: begin
        result_o = mul_shifted[Width-1:0];
      end
      VMACC: begin
        result_o = mul_low + op_d_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule : ipu_simd_lane

`default_nettype wire

/* hdl/ipu_vfu.sv */
//////////////////////////////////////////////////
// Integer vector functional unit top level
// Issue/result register stage around the core
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipu_vfu (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Issue side
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  ipu_pkg::op_e                operation_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_s1_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_s2_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_d_i,
  input  logic [ipu_pkg::ELENB-1:0]   carry_i,
  input  ipu_pkg::vew_e               sew_i,
  input  logic [ipu_pkg::ACT_W-1:0]   act_elems_i,
  // Result side
  output logic                        res_valid_o,
  input  logic                        res_ready_i,
  output logic [ipu_pkg::ELEN-1:0]    result_o,
  output logic [ipu_pkg::ELENB-1:0]   be_o
);

  import ipu_pkg::*;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  logic [ELEN-1:0]  core_result;
  logic [ELENB-1:0] core_be;

  logic             issue_fire;
  logic             res_valid_q;
  logic [ELEN-1:0]  result_q;
  logic [ELENB-1:0] be_q;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Free slot, or the held result leaves this cycle
  assign in_ready_o = !res_valid_q || res_ready_i;
  assign issue_fire = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (issue_fire) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  // Result payload, held while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      result_q <= core_result;
      be_q     <= core_be;
    end
  end

  assign res_valid_o = res_valid_q;
  assign result_o    = result_q;
  assign be_o        = be_q;

  //////////////////////////////////////////////////
  // Core
  //////////////////////////////////////////////////

  ipu_core i_ipu_core (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operation_i (operation_i),
    .op_s1_i     (op_s1_i),
    .op_s2_i     (op_s2_i),
    .op_d_i      (op_d_i),
    .carry_i     (carry_i),
    .sew_i       (sew_i),
    .act_elems_i (act_elems_i),
    .be_o        (core_be),
    .result_o    (core_result)
  );

endmodule : ipu_vfu

`default_nettype wire

/* ipu.f */
hdl/ipu_pkg.sv
hdl/ipu_simd_lane.sv
hdl/ipu_core.sv
hdl/ipu_vfu.sv
sim/ipu_properties.sv
sim/ipu_checker.sv
sim/ipu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the IPU testbench with Verilator, result decided from sim.log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module ipu_tb -f ipu.f -o ipu_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/ipu_sim > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without passing"; exit 1; }

echo "Simulation passed"
exit 0

/* sim/ipu_checker.sv */
//////////////////////////////////////////////////
// Result checker for the integer vector unit
// Reference model, expected queue, comparison
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipu_checker (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        in_valid_i,
  input  logic                        in_ready_i,
  input  ipu_pkg::op_e                operation_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_s1_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_s2_i,
  input  logic [ipu_pkg::ELEN-1:0]    op_d_i,
  input  logic [ipu_pkg::ELENB-1:0]   carry_i,
  input  ipu_pkg::vew_e               sew_i,
  input  logic [ipu_pkg::ACT_W-1:0]   act_elems_i,
  input  logic                        res_valid_i,
  input  logic                        res_ready_i,
  input  logic [ipu_pkg::ELEN-1:0]    result_i,
  input  logic [ipu_pkg::ELENB-1:0]   be_i,
  output int unsigned                 mismatch_cnt_o,
  output int unsigned                 orphan_cnt_o,
  output int unsigned                 checked_cnt_o
);

  import ipu_pkg::*;

  // Expected entries hold {be, result}
  logic [ELENB+ELEN-1:0] expected_q [$];
  logic [ELENB+ELEN-1:0] exp_entry;
  int unsigned           mismatch_cnt = 0;
  int unsigned           orphan_cnt   = 0;
  int unsigned           checked_cnt  = 0;

  assign mismatch_cnt_o = mismatch_cnt;
  assign orphan_cnt_o   = orphan_cnt;
  assign checked_cnt_o  = checked_cnt;

  //////////////////////////////////////////////////
  // Reference model, element by element
  //////////////////////////////////////////////////

  function automatic logic [ELENB+ELEN-1:0] ipu_ref(
    input op_e op, input logic [ELEN-1:0] s1, input logic [ELEN-1:0] s2,
    input logic [ELEN-1:0] d, input logic [ELENB-1:0] cin, input vew_e ew,
    input logic [ACT_W-1:0] act);
    int unsigned      w;
    int unsigned      k;
    int unsigned      bi;
    longint unsigned  mask;
    longint unsigned  sbit;
    longint unsigned  a, b, c, ci, r;
    longint           sa, sb;
    logic [ELEN-1:0]  res;
    logic [ELENB-1:0] ben;
    w    = (ew == EW_8) ? 8 : ((ew == EW_16) ? 16 : 32);
    mask = (64'd1 << w) - 64'd1;
    sbit = 64'd1 << (w - 1);
    res  = '0;
    ben  = '0;
    for (k = 0; k < ELEN / w; k++) begin
      a  = 64'(s1 >> (k * w)) & mask;
      b  = 64'(s2 >> (k * w)) & mask;
      c  = 64'(d >> (k * w)) & mask;
      ci = 64'((cin >> k) & 4'h1);
      sa = longint'(a ^ sbit) - longint'(sbit);
      sb = longint'(b ^ sbit) - longint'(sbit);
      case (op)
        VADD:    r = a + b;
        VSUB:    r = a - b;
        VADC:    r = a + b + ci;
        VSBC:    r = a - b - ci;
        VAND:    r = a & b;
        VOR:     r = a | b;
        VXOR:    r = a ^ b;
        VMINU:   r = (a < b) ? a : b;
        VMIN:    r = (sa < sb) ? a : b;
        VMAXU:   r = (a < b) ? b : a;
        VMAX:    r = (sa < sb) ? b : a;
        VMUL:    r = a * b;
        VMULH:   r = 64'((sa * sb) >>> w);
        VMACC:   r = a * b + c;
        default: r = 64'd0;
      endcase
      res = res | (ELEN'(r & mask) << (k * w));
    end
    // Byte is enabled when its element index is below the count
    for (bi = 0; bi < ELENB; bi++) begin
      if (bi / (w / 8) < 32'(act)) begin
        ben = ben | (ELENB'(1) << bi);
      end
    end
    return {ben, res};
  endfunction

  //////////////////////////////////////////////////
  // Compare on result transfer, record on issue
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (res_valid_i && res_ready_i) begin
        if (expected_q.size() == 0) begin
          orphan_cnt++;
          $display("Error at %0t ns: a result was returned with no operation outstanding",
                   $time);
        end else begin
          exp_entry = expected_q.pop_front();
          checked_cnt++;
          if (result_i !== exp_entry[ELEN-1:0]) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: result_o is %h, expected %h",
                     $time, result_i, exp_entry[ELEN-1:0]);
          end
          if (be_i !== exp_entry[ELEN +: ELENB]) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: be_o is %b, expected %b",
                     $time, be_i, exp_entry[ELEN +: ELENB]);
          end
        end
      end
      if (in_valid_i && in_ready_i) begin
        expected_q.push_back(ipu_ref(operation_i, op_s1_i, op_s2_i, op_d_i,
                                     carry_i, sew_i, act_elems_i));
      end
    end
  end

endmodule : ipu_checker

`default_nettype wire

/* sim/ipu_properties.sv */
//////////////////////////////////////////////////
// Handshake assertions for the vector unit top
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipu_properties (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        in_valid_i,
  input logic                        in_ready_i,
  input logic                        res_valid_i,
  input logic                        res_ready_i,
  input logic [ipu_pkg::ELEN-1:0]    result_i,
  input logic [ipu_pkg::ELENB-1:0]   be_i
);

  // Failed assertion count for the closing report
  int unsigned fail_cnt = 0;

  // No result while in reset, nor on the first edge after it
  a_no_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !res_valid_i)
    else begin
      $error("res_valid_o high during reset");
      fail_cnt++;
    end
  a_no_valid_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !res_valid_i)
    else begin
      $error("res_valid_o high right after reset release");
      fail_cnt++;
    end

  // Stalled result holds
  a_result_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(result_i) && $stable(be_i))
    else begin
      $error("Result changed while stalled");
      fail_cnt++;
    end

  a_issue_gives_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i && in_ready_i |=> res_valid_i)
    else begin
      $error("No result one cycle after an accepted issue");
      fail_cnt++;
    end

endmodule : ipu_properties

bind ipu_vfu ipu_properties i_ipu_properties (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .in_valid_i  (in_valid_i),
  .in_ready_i  (in_ready_o),
  .res_valid_i (res_valid_o),
  .res_ready_i (res_ready_i),
  .result_i    (result_o),
  .be_i        (be_o)
);

`default_nettype wire

/* sim/ipu_tb.sv */
//////////////////////////////////////////////////
// Testbench top for the integer vector unit
// Clock, reset, random and corner stimulus,
// result back-pressure, watchdog, closing report
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipu_tb;

  import ipu_pkg::*;

  localparam int unsigned CLK_PERIOD      = 40;
  localparam int unsigned RESET_CYCLES    = 10;
  localparam int unsigned NUM_RANDOM      = 400;
  localparam int unsigned NUM_OPCODES     = 14;
  localparam int unsigned NUM_CORNER_VALS = 9;
  localparam int unsigned NUM_OPS         = NUM_RANDOM + 3 * NUM_OPCODES * NUM_CORNER_VALS + 3 * 8;
  localparam int unsigned WATCHDOG_NS     = 4 * NUM_OPS * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic             in_ready;
  op_e              operation;
  logic [ELEN-1:0]  op_s1;
  logic [ELEN-1:0]  op_s2;
  logic [ELEN-1:0]  op_d;
  logic [ELENB-1:0] carry;
  vew_e             sew;
  logic [ACT_W-1:0] act_elems;
  logic             res_valid;
  logic             res_ready;
  logic [ELEN-1:0]  result;
  logic [ELENB-1:0] be;

  int unsigned      issued_cnt;
  int unsigned      mismatch_cnt;
  int unsigned      orphan_cnt;
  int unsigned      checked_cnt;

  // Operand i is paired with its mirror NUM_CORNER_VALS-1-i
  logic [ELEN-1:0]  corner_vals [NUM_CORNER_VALS] = '{
    32'h0000_0000, 32'h8080_8080, 32'h8000_8000, 32'h8000_0000, 32'h01FF_80FE,
    32'h7FFF_FFFF, 32'h7FFF_7FFF, 32'h7F7F_7F7F, 32'hFFFF_FFFF
  };

  ipu_vfu UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .operation_i (operation),
    .op_s1_i     (op_s1),
    .op_s2_i     (op_s2),
    .op_d_i      (op_d),
    .carry_i     (carry),
    .sew_i       (sew),
    .act_elems_i (act_elems),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .result_o    (result),
    .be_o        (be)
  );

  ipu_checker i_ipu_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .in_valid_i     (in_valid),
    .in_ready_i     (in_ready),
    .operation_i    (operation),
    .op_s1_i        (op_s1),
    .op_s2_i        (op_s2),
    .op_d_i         (op_d),
    .carry_i        (carry),
    .sew_i          (sew),
    .act_elems_i    (act_elems),
    .res_valid_i    (res_valid),
    .res_ready_i    (res_ready),
    .result_i       (result),
    .be_i           (be),
    .mismatch_cnt_o (mismatch_cnt),
    .orphan_cnt_o   (orphan_cnt),
    .checked_cnt_o  (checked_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Consumer stalls roughly one cycle in three
  always @(posedge clk) begin
    #2;
    res_ready = ($urandom_range(0, 2) != 0);
  end

  // Holds one operation on the issue port until it is accepted
  task automatic issue_op(input op_e op, input logic [ELEN-1:0] s1, input logic [ELEN-1:0] s2,
                          input logic [ELEN-1:0] d, input logic [ELENB-1:0] cin,
                          input vew_e ew, input logic [ACT_W-1:0] act);
    logic accepted;
    in_valid  = 1'b1;
    operation = op;
    op_s1     = s1;
    op_s2     = s2;
    op_d      = d;
    carry     = cin;
    sew       = ew;
    act_elems = act;
    accepted  = 1'b0;
    while (!accepted) begin
      // Ready is settled by mid cycle
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
      #2;
    end
    in_valid = 1'b0;
    issued_cnt++;
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: results still outstanding after %0d ns, %0d of %0d checked",
             WATCHDOG_NS, checked_cnt, issued_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned i;
    int unsigned si;
    int unsigned oi;
    int unsigned vi;
    int unsigned total_errors;
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    operation  = VADD;
    op_s1      = '0;
    op_s2      = '0;
    op_d       = '0;
    carry      = '0;
    sew        = EW_8;
    act_elems  = '0;
    res_ready  = 1'b1;
    issued_cnt = 0;
    void'($urandom(70773));

    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    // Random mix over every op, width, carry and count
    for (i = 0; i < NUM_RANDOM; i++) begin
      issue_op(op_e'(4'($urandom_range(0, NUM_OPCODES - 1))), $urandom, $urandom, $urandom,
               ELENB'($urandom), vew_e'(2'($urandom_range(0, 2))), ACT_W'($urandom_range(0, 7)));
    end

    // Corner operands at extreme signed and unsigned values
    for (si = 0; si < 3; si++) begin
      for (oi = 0; oi < NUM_OPCODES; oi++) begin
        for (vi = 0; vi < NUM_CORNER_VALS; vi++) begin
          issue_op(op_e'(4'(oi)), corner_vals[4'(vi)],
                   corner_vals[4'(NUM_CORNER_VALS - 1 - vi)],
                   corner_vals[4'((vi + 2) % NUM_CORNER_VALS)],
                   (vi % 3 == 0) ? 4'hF : ((vi % 3 == 1) ? 4'h0 : 4'h5),
                   vew_e'(2'(si)), ACT_W'(4));
        end
      end
    end

    // Byte enable sweep over zero and saturated counts
    for (si = 0; si < 3; si++) begin
      for (vi = 0; vi < 8; vi++) begin
        issue_op(VADD, 32'h1234_5678, 32'h0F0F_F0F0, '0, '0, vew_e'(2'(si)), ACT_W'(vi));
      end
    end

    wait (checked_cnt == issued_cnt);
    repeat (4) @(posedge clk);

    total_errors = mismatch_cnt + orphan_cnt + UUT.i_ipu_properties.fail_cnt;
    $display("Errors: %0d total (%0d mismatch, %0d unexpected, %0d assertion), %0d checked",
             total_errors, mismatch_cnt, orphan_cnt, UUT.i_ipu_properties.fail_cnt,
             checked_cnt);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : ipu_tb

`default_nettype wire
